// ==== Bender.yml ====
package:
  name: lsu

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_pkg.sv
      - src/axi_lite_pkg.sv
      - src/store_align.sv
      - src/load_extend.sv
      - src/lsu_axi_master.sv
      - src/data_ram.sv
      - src/lsu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_lsu.sv

// ==== src.f ====
+incdir+src
src/lsu_pkg.sv
src/axi_lite_pkg.sv
src/store_align.sv
src/load_extend.sv
src/lsu_axi_master.sv
src/data_ram.sv
src/lsu_top.sv
tests/tb_lsu.sv

// ==== src/axi_lite_pkg.sv ====
// axi4-lite channel types
`default_nettype none
`include "lsu_settings.svh"

package axi_lite_pkg;

  // response codes, only okay is produced here
  localparam logic [1:0] AXIL_OKAY = 2'b00;

  // write address channel
  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
  } axil_aw_t;

  // write data channel
  typedef struct packed {
    logic [`LSU_XLEN-1:0]   data;
    logic [`LSU_XLEN/8-1:0] strb; // one bit per byte lane
  } axil_w_t;

  // write response channel
  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  // read address channel
  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
  } axil_ar_t;

  // read data channel
  typedef struct packed {
    logic [`LSU_XLEN-1:0] data;
    logic [1:0]           resp;
  } axil_r_t;

endpackage

`default_nettype wire

// ==== src/data_ram.sv ====
// axi4-lite data ram
`default_nettype none
`include "lsu_settings.svh"

module data_ram (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,      // sync, active low
  input  wire axi_lite_pkg::axil_aw_t i_aw,
  input  wire logic                   i_aw_valid,
  output logic                        o_aw_ready,
  input  wire axi_lite_pkg::axil_w_t  i_w,
  input  wire logic                   i_w_valid,
  output logic                        o_w_ready,
  output axi_lite_pkg::axil_b_t       o_b,
  output logic                        o_b_valid,
  input  wire logic                   i_b_ready,
  input  wire axi_lite_pkg::axil_ar_t i_ar,
  input  wire logic                   i_ar_valid,
  output logic                        o_ar_ready,
  output axi_lite_pkg::axil_r_t       o_r,
  output logic                        o_r_valid,
  input  wire logic                   i_r_ready
);

  localparam int OFF_W = $clog2(`LSU_XLEN / 8); // byte offset bits

  logic [`LSU_XLEN-1:0]   mem [`LSU_RAM_WORDS]; // word storage
  logic [`LSU_RAM_AW-1:0] widx, ridx;
  logic [`LSU_XLEN-1:0]   rdata_q;              // registered read word
  logic                   b_vld_q, r_vld_q;
  logic                   wr_en, rd_en;

  // word index sits right above the byte offset
  assign widx = i_aw.addr[OFF_W +: `LSU_RAM_AW];
  assign ridx = i_ar.addr[OFF_W +: `LSU_RAM_AW];

  // aw and w go in together, and only when no b is waiting
  assign wr_en      = i_aw_valid & i_w_valid & ~b_vld_q;
  assign o_aw_ready = wr_en;
  assign o_w_ready  = wr_en;
  assign o_ar_ready = ~r_vld_q; // one read in flight
  assign rd_en      = i_ar_valid & o_ar_ready;

  assign o_b_valid = b_vld_q;
  assign o_b.resp  = axi_lite_pkg::AXIL_OKAY;
  assign o_r_valid = r_vld_q;
  assign o_r.data  = rdata_q;
  assign o_r.resp  = axi_lite_pkg::AXIL_OKAY;

  // strobed byte writes
  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      for (int i = 0; i < `LSU_XLEN / 8; i++) begin
        if (i_w.strb[i]) mem[widx][8*i +: 8] <= i_w.data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_en) rdata_q <= mem[ridx]; // stays put until the next ar
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      b_vld_q <= 1'b0;
      r_vld_q <= 1'b0;
    end else begin
      if (wr_en)                b_vld_q <= 1'b1;
      else if (i_b_ready)       b_vld_q <= 1'b0;
      if (rd_en)                r_vld_q <= 1'b1;
      else if (i_r_ready)       r_vld_q <= 1'b0;
    end
  end

  // rvalid and the word held until the master takes them
  a_r_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
    o_r_valid && !i_r_ready |=> o_r_valid && $stable(o_r))
    else $error("data_ram: rvalid dropped before rready");

endmodule

`default_nettype wire

// ==== src/load_extend.sv ====
// load lane select and extend
`default_nettype none
`include "lsu_settings.svh"

module load_extend (
  input  wire lsu_pkg::mem_op_u     i_op,      // size and signedness
  input  wire logic [2:0]           i_addr_lo, // byte offset of the access
  input  wire logic [`LSU_XLEN-1:0] i_word,    // raw word from the r channel
  output logic [`LSU_XLEN-1:0]      o_data     // extended load result
);

  logic [`LSU_XLEN-1:0] shifted; // addressed byte moved down to lane 0
  logic                 sgn;     // sign bit of the selected field

  assign shifted = i_word >> {i_addr_lo, 3'b000};

  always_comb begin
    case (i_op.f.size)
      lsu_pkg::MEM_BYTE: begin
        sgn    = shifted[7] & ~i_op.f.unsgn;
        o_data = {{56{sgn}}, shifted[7:0]};
      end
      lsu_pkg::MEM_HALF: begin
        sgn    = shifted[15] & ~i_op.f.unsgn;
        o_data = {{48{sgn}}, shifted[15:0]};
      end
      lsu_pkg::MEM_WORD: begin
        sgn    = shifted[31] & ~i_op.f.unsgn;
        o_data = {{32{sgn}}, shifted[31:0]};
      end
      default: begin
        // double is the whole word, offset is zero when aligned
        sgn    = 1'b0;
        o_data = i_word;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/lsu_axi_master.sv ====
// lsu axi4-lite master
`default_nettype none
`include "lsu_settings.svh"

module lsu_axi_master (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,       // sync, active low
  input  wire lsu_pkg::lsu_req_t      i_req,
  input  wire logic                   i_req_valid,
  output logic                        o_req_ready,
  output lsu_pkg::lsu_rsp_t           o_rsp,
  output logic                        o_rsp_valid,
  input  wire logic                   i_rsp_ready,
  output axi_lite_pkg::axil_aw_t      o_aw,
  output logic                        o_aw_valid,
  input  wire logic                   i_aw_ready,
  output axi_lite_pkg::axil_w_t       o_w,
  output logic                        o_w_valid,
  input  wire logic                   i_w_ready,
  input  wire axi_lite_pkg::axil_b_t  i_b,
  input  wire logic                   i_b_valid,
  output logic                        o_b_ready,
  output axi_lite_pkg::axil_ar_t      o_ar,
  output logic                        o_ar_valid,
  input  wire logic                   i_ar_ready,
  input  wire axi_lite_pkg::axil_r_t  i_r,
  input  wire logic                   i_r_valid,
  output logic                        o_r_ready
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_WRITE, ST_WRESP, ST_READ, ST_RRESP, ST_RESP
  } state_e;

  state_e               state_q, state_d;
  lsu_pkg::lsu_req_t    req_q;             // request held for the whole access
  lsu_pkg::lsu_rsp_t    rsp_q;             // response payload
  logic                 aw_pend_q;         // aw not yet taken by the slave
  logic                 w_pend_q;          // w not yet taken by the slave
  logic [7:0]           st_strb;
  logic [`LSU_XLEN-1:0] st_data;
  logic [`LSU_XLEN-1:0] ld_data;
  logic                 req_hs, aw_hs, w_hs, b_hs, ar_hs, r_hs, rsp_hs;
  logic                 req_none;          // incoming request skips the bus

  store_align u_store_align (
    .i_op      (req_q.op),
    .i_addr_lo (req_q.addr[2:0]),
    .i_data    (req_q.data),
    .o_strb    (st_strb),
    .o_data    (st_data)
  );

  load_extend u_load_extend (
    .i_op      (req_q.op),
    .i_addr_lo (req_q.addr[2:0]),
    .i_word    (i_r.data),
    .o_data    (ld_data)
  );

  assign o_req_ready = (state_q == ST_IDLE);
  assign o_rsp_valid = (state_q == ST_RESP);
  assign o_aw_valid  = aw_pend_q;
  assign o_w_valid   = w_pend_q;
  assign o_b_ready   = (state_q == ST_WRESP);
  assign o_ar_valid  = (state_q == ST_READ);
  assign o_r_ready   = (state_q == ST_RRESP);
  assign o_rsp       = rsp_q;

  assign req_hs = i_req_valid & o_req_ready;
  assign aw_hs  = o_aw_valid & i_aw_ready;
  assign w_hs   = o_w_valid & i_w_ready;
  assign b_hs   = i_b_valid & o_b_ready;
  assign ar_hs  = o_ar_valid & i_ar_ready;
  assign r_hs   = i_r_valid & o_r_ready;
  assign rsp_hs = o_rsp_valid & i_rsp_ready;

  assign req_none = (i_req.op.raw == lsu_pkg::MEM_OP_NONE);

  // channel payloads come straight from the held request, stable while valid
  always_comb begin
    o_aw.addr = req_q.addr;
    o_w.data  = st_data;
    o_w.strb  = st_strb;
    o_ar.addr = req_q.addr;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_hs) begin
          if (req_none)      state_d = ST_RESP;
          else if (i_req.we) state_d = ST_WRITE;
          else               state_d = ST_READ;
        end
      end
      ST_WRITE: begin
        // aw and w may finish in either order
        if ((!aw_pend_q || i_aw_ready) && (!w_pend_q || i_w_ready)) state_d = ST_WRESP;
      end
      ST_WRESP: if (b_hs)   state_d = ST_RESP;
      ST_READ:  if (ar_hs)  state_d = ST_RRESP;
      ST_RRESP: if (r_hs)   state_d = ST_RESP;
      ST_RESP:  if (rsp_hs) state_d = ST_IDLE;
      default:              state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      state_q   <= ST_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (req_hs && i_req.we && !req_none) begin
        aw_pend_q <= 1'b1; // both raised the cycle after acceptance
        w_pend_q  <= 1'b1;
      end else begin
        if (aw_hs) aw_pend_q <= 1'b0;
        if (w_hs)  w_pend_q  <= 1'b0;
      end
    end
  end

  // payload registers
  always_ff @(posedge i_clk) begin
    if (req_hs) begin
      req_q      <= i_req;
      rsp_q.data <= '0; // stores and no-access answer with zero
    end else if (r_hs) begin
      rsp_q.data <= ld_data;
    end
  end

  // the slave only ever answers okay
  a_resp_okay: assert property (@(posedge i_clk) disable iff (!i_rst)
    !(b_hs && i_b.resp != axi_lite_pkg::AXIL_OKAY) &&
    !(r_hs && i_r.resp != axi_lite_pkg::AXIL_OKAY))
    else $error("lsu_axi_master: non-okay bus response");

  // response held under back-pressure
  a_rsp_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
    else $error("lsu_axi_master: response dropped before ready");

endmodule

`default_nettype wire

// ==== src/lsu_pkg.sv ====
// load store unit types
`default_nettype none
`include "lsu_settings.svh"

package lsu_pkg;

  // access size, taken from op code bits [2:1]
  typedef enum logic [1:0] {
    MEM_BYTE   = 2'b00,
    MEM_HALF   = 2'b01,
    MEM_WORD   = 2'b10,
    MEM_DOUBLE = 2'b11
  } mem_size_e;

  // decoded view of the op code
  typedef struct packed {
    mem_size_e size;  // access width
    logic      unsgn; // 1 = zero extend on load
  } mem_op_fields_t;

  // one 3-bit code, read raw or as fields
  typedef union packed {
    logic [2:0]     raw; // compared against the no-access code
    mem_op_fields_t f;   // drives mask and extension
  } mem_op_u;

  // code 111 means no memory access at all
  localparam logic [2:0] MEM_OP_NONE = 3'b111;

  // request from the core side
  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr; // byte address
    logic [`LSU_XLEN-1:0] data; // store data, low aligned
    mem_op_u              op;
    logic                 we;   // 1 = store
  } lsu_req_t;

  // response back to the core
  typedef struct packed {
    logic [`LSU_XLEN-1:0] data; // extended load data, zero for stores
  } lsu_rsp_t;

endpackage

`default_nettype wire

// ==== src/lsu_settings.svh ====
// lsu build settings
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width of the core
`define LSU_XLEN 64

// data ram depth in xlen words
`define LSU_RAM_WORDS 512

// word index width, log2 of the depth
`define LSU_RAM_AW 9

`endif

// ==== src/lsu_top.sv ====
// lsu with data ram
`default_nettype none

module lsu_top (
  input  wire logic              i_clk,
  input  wire logic              i_rst,       // sync, active low
  input  wire lsu_pkg::lsu_req_t i_req,
  input  wire logic              i_req_valid,
  output logic                   o_req_ready,
  output lsu_pkg::lsu_rsp_t      o_rsp,
  output logic                   o_rsp_valid,
  input  wire logic              i_rsp_ready
);

  axi_lite_pkg::axil_aw_t aw;
  axi_lite_pkg::axil_w_t  w;
  axi_lite_pkg::axil_b_t  b;
  axi_lite_pkg::axil_ar_t ar;
  axi_lite_pkg::axil_r_t  r;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready;

  lsu_axi_master u_master (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req       (i_req),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .o_rsp       (o_rsp),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_aw        (aw),
    .o_aw_valid  (aw_valid),
    .i_aw_ready  (aw_ready),
    .o_w         (w),
    .o_w_valid   (w_valid),
    .i_w_ready   (w_ready),
    .i_b         (b),
    .i_b_valid   (b_valid),
    .o_b_ready   (b_ready),
    .o_ar        (ar),
    .o_ar_valid  (ar_valid),
    .i_ar_ready  (ar_ready),
    .i_r         (r),
    .i_r_valid   (r_valid),
    .o_r_ready   (r_ready)
  );

  data_ram u_ram (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_aw       (aw),
    .i_aw_valid (aw_valid),
    .o_aw_ready (aw_ready),
    .i_w        (w),
    .i_w_valid  (w_valid),
    .o_w_ready  (w_ready),
    .o_b        (b),
    .o_b_valid  (b_valid),
    .i_b_ready  (b_ready),
    .i_ar       (ar),
    .i_ar_valid (ar_valid),
    .o_ar_ready (ar_ready),
    .o_r        (r),
    .o_r_valid  (r_valid),
    .i_r_ready  (r_ready)
  );

endmodule

`default_nettype wire

// ==== src/store_align.sv ====
// store mask and lane shifter
`default_nettype none
`include "lsu_settings.svh"

module store_align (
  input  wire lsu_pkg::mem_op_u     i_op,      // op code of the held request
  input  wire logic [2:0]           i_addr_lo, // byte offset inside the word
  input  wire logic [`LSU_XLEN-1:0] i_data,    // store data, low aligned
  output logic [7:0]                o_strb,    // byte strobe for the w channel
  output logic [`LSU_XLEN-1:0]      o_data     // data replicated across lanes
);

  logic [7:0] base_mask; // mask before the offset shift
  logic       aligned;   // offset is a multiple of the size

  always_comb begin
    case (i_op.f.size)
      lsu_pkg::MEM_BYTE: begin
        base_mask = 8'h01;
        o_data    = {8{i_data[7:0]}};
        aligned   = 1'b1;
      end
      lsu_pkg::MEM_HALF: begin
        base_mask = 8'h03;
        o_data    = {4{i_data[15:0]}};
        aligned   = (i_addr_lo[0] == 1'b0);
      end
      lsu_pkg::MEM_WORD: begin
        base_mask = 8'h0f;
        o_data    = {2{i_data[31:0]}};
        aligned   = (i_addr_lo[1:0] == 2'b00);
      end
      default: begin // double, also code 111
        base_mask = 8'hff;
        o_data    = i_data;
        aligned   = (i_addr_lo == 3'b000);
      end
    endcase
  end

  // no-access kills every lane, otherwise slide mask up to the offset
  assign o_strb = (i_op.raw == lsu_pkg::MEM_OP_NONE) ? 8'h00 : (base_mask << i_addr_lo);

  // misaligned accesses are never split, so they must not reach the bus
  always_comb begin
    assert final ($isunknown(i_op) || i_op.raw == lsu_pkg::MEM_OP_NONE || aligned)
      else $error("store_align: misaligned op %b at offset %0d", i_op.raw, i_addr_lo);
  end

endmodule

`default_nettype wire

// ==== tests/tb_lsu.sv ====
// lsu testbench
`default_nettype none
`include "lsu_settings.svh"

module tb_lsu;

  logic              i_clk;
  logic              i_rst;
  lsu_pkg::lsu_req_t i_req;
  logic              i_req_valid;
  logic              o_req_ready;
  lsu_pkg::lsu_rsp_t o_rsp;
  logic              o_rsp_valid;
  logic              i_rsp_ready;

  logic [7:0]           model [`LSU_RAM_WORDS*8]; // byte image of the ram
  logic [`LSU_XLEN-1:0] exp_q [$];                // expected data in request order
  integer               seed;
  integer               bp_seed;                  // own stream for the ready driver
  integer               errors;
  integer               rsp_count;
  logic                 bp_on;                    // random back-pressure enable
  integer               bp_left;                  // cycles left in this ready stretch
  logic                 hold_q;                   // last edge had valid without ready
  logic [`LSU_XLEN-1:0] hold_data;

  lsu_top i_dut (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req       (i_req),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .o_rsp       (o_rsp),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // fill word that carries every address bit
  function automatic logic [`LSU_XLEN-1:0] fill_word(input logic [11:0] a);
    return {20'hc3a59, a, 20'h6e1f0, ~a};
  endfunction

  // expected load result from the byte model
  function automatic logic [`LSU_XLEN-1:0] ref_load(input logic [2:0] op,
                                                    input logic [11:0] addr);
    logic [`LSU_XLEN-1:0] val;
    int                   nbytes;
    val    = '0;
    nbytes = 1 << op[2:1];
    if (op == 3'b111) return '0; // no access reads nothing
    for (int i = 0; i < nbytes; i++) val[8*i +: 8] = model[addr + i];
    if (!op[0] && nbytes < 8 && val[8*nbytes-1])
      val = val | ({`LSU_XLEN{1'b1}} << (8*nbytes)); // negative field
    return val;
  endfunction

  // store into the model with the low data bytes from addr upward
  task automatic apply_store(input logic [2:0] op, input logic [11:0] addr,
                             input logic [`LSU_XLEN-1:0] data);
    int nbytes;
    nbytes = 1 << op[2:1];
    if (op != 3'b111) begin
      for (int i = 0; i < nbytes; i++) model[addr + i] = data[8*i +: 8];
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s at t=%0t", msg, $time);
    $display("checks done: %0d responses, %0d errors", rsp_count, errors + 1);
    $display("TEST FAILED");
    $finish;
  endtask

  // one request from falling edge to falling edge
  task automatic send_req(input logic [2:0] op, input logic [11:0] addr,
                          input logic [`LSU_XLEN-1:0] data, input logic we);
    logic [`LSU_XLEN-1:0] exp;
    int                   waited;
    exp          = (we || op == 3'b111) ? '0 : ref_load(op, addr);
    i_req.addr   = {{(`LSU_XLEN-12){1'b0}}, addr};
    i_req.data   = data;
    i_req.op.raw = op;
    i_req.we     = we;
    i_req_valid  = 1'b1;
    waited       = 0;
    do begin
      @(posedge i_clk);
      waited++;
      if (waited > 200) abort_run("timeout waiting for the dut to accept a request");
    end while (!o_req_ready);
    exp_q.push_back(exp); // taken on this edge
    if (we) apply_store(op, addr, data);
    @(negedge i_clk);
    i_req_valid = 1'b0;
  endtask

  // response ready in random stretches high or low
  always @(negedge i_clk) begin
    if (!bp_on) begin
      i_rsp_ready <= 1'b1;
    end else if (bp_left == 0) begin
      i_rsp_ready <= $random(bp_seed) & 1;
      bp_left     <= 1 + ($random(bp_seed) & 3);
    end else begin
      bp_left <= bp_left - 1;
    end
  end

  // response checker
  always @(posedge i_clk) begin : compare_rsp
    logic [`LSU_XLEN-1:0] exp;
    if (i_rst) begin
      if (hold_q) begin
        assert (o_rsp_valid === 1'b1 && o_rsp.data === hold_data) else begin
          errors++;
          $display("error: t=%0t response moved under back-pressure, valid %b data %h held %h",
                   $time, o_rsp_valid, o_rsp.data, hold_data);
        end
      end
      assert (!(o_rsp_valid && o_req_ready)) else begin
        errors++;
        $display("error: t=%0t request ready while a response is pending", $time);
      end
      if (o_rsp_valid && i_rsp_ready) begin
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("a response arrived with no request outstanding at t=%0t", $time);
        end
        if (exp_q.size() > 0) begin
          exp = exp_q.pop_front();
          rsp_count++;
          assert (o_rsp.data === exp) else begin
            errors++;
            $display("error: t=%0t load data %h, expected %h", $time, o_rsp.data, exp);
          end
        end
      end
      hold_q    <= o_rsp_valid && !i_rsp_ready;
      hold_data <= o_rsp.data;
    end else begin
      hold_q <= 1'b0;
    end
  end

  initial begin : stimulus
    logic [2:0]           op;
    logic [11:0]          addr;
    logic [11:0]          ld_addr;
    logic [`LSU_XLEN-1:0] data;
    logic [31:0]          rnd;
    int                   waited;
    seed        = 32'h26ea_356c;
    bp_seed     = ~seed;
    errors      = 0;
    rsp_count   = 0;
    bp_on       = 1'b0;
    bp_left     = 0;
    hold_q      = 1'b0;
    i_rst       = 1'b0;
    i_req       = '0;
    i_req_valid = 1'b0;
    i_rsp_ready = 1'b1;
    repeat (8) @(negedge i_clk);
    i_rst = 1'b1;
    assert (o_req_ready === 1'b1 && o_rsp_valid === 1'b0) else begin
      errors++;
      $display("error: t=%0t wrong state after reset, req_ready %b rsp_valid %b",
               $time, o_req_ready, o_rsp_valid);
    end

    // whole ram gets a known pattern first
    for (int w = 0; w < `LSU_RAM_WORDS; w++) send_req(3'b110, w * 8, fill_word(w * 8), 1'b1);

    // every store size and offset, then every load code on it
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        addr = 12'h100 + off;
        data = ((off >> s) & 1) ? 64'h1122_3344_5566_7708 : 64'h8091_a2b3_c4d5_e6f7;
        send_req({s[1:0], 1'b0}, addr, data, 1'b1);
        for (int c = 0; c < 8; c++) begin
          ld_addr = addr & ~((12'd1 << c[2:1]) - 12'd1);
          send_req(c[2:0], ld_addr, '0, 1'b0);
        end
      end
    end

    // partial stores keep their neighbours
    send_req(3'b110, 12'h208, 64'h0123_4567_89ab_cdef, 1'b1);
    send_req(3'b000, 12'h20d, 64'h0000_0000_0000_0080, 1'b1); // byte lane 5
    send_req(3'b010, 12'h20a, 64'hffff_ffff_ffff_7e5a, 1'b1); // half lane 2
    send_req(3'b110, 12'h208, '0, 1'b0);

    // no-access as write and as read leaves memory untouched
    send_req(3'b111, 12'h300, 64'hdead_beef_dead_beef, 1'b1);
    send_req(3'b111, 12'h300, '0, 1'b0);
    send_req(3'b110, 12'h300, '0, 1'b0);

    // random aligned traffic under back-pressure
    bp_on <= 1'b1;
    repeat (300) begin
      rnd     = $random(seed);
      op      = rnd[2:0];
      addr    = $random(seed);
      addr    = addr & ~((12'd1 << op[2:1]) - 12'd1);
      data    = {$random(seed), $random(seed)};
      send_req(op, addr, data, rnd[3]);
    end

    bp_on  <= 1'b0;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge i_clk);
      waited++;
      if (waited > 200) abort_run("timeout waiting for the last responses");
    end

    $display("checks done: %0d responses, %0d errors", rsp_count, errors);
    if (errors == 0) $display("TEST PASSED");
    else $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
